//--- hdl/i2c_bit_ctl.sv
`timescale 1ns/1ps

module i2c_bit_ctl
    import i2c_pkg::*;
(
    input  logic      sysclk_i,
    input  logic      reset_n_i,
    input  logic      enable_i,
    input  prescale_t prescale_i,
    input  bit_cmd_e  cmd_i,
    input  logic      bit_i,
    input  logic      scl_i,
    input  logic      sda_i,
    output logic      cmd_ack_o,
    output logic      bit_o,
    output logic      arblost_o,
    output logic      busy_o,
    output logic      scl_oen_o,
    output logic      sda_oen_o
);

    prescale_t  cnt;
    logic       tick;
    bit_state_e state;
    logic [1:0] scl_sync;
    logic [1:0] sda_sync;
    logic       sda_last;
    logic       scl_hi;
    logic       sda_hi;

    assign scl_hi = scl_sync[1];
    assign sda_hi = sda_sync[1];

    // bring the bus lines into the clock domain
    always_ff @(posedge sysclk_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            scl_sync <= 2'b11;
            sda_sync <= 2'b11;
            sda_last <= 1'b1;
        end
        else
        begin
            scl_sync <= {scl_sync[0], scl_i};
            sda_sync <= {sda_sync[0], sda_i};
            sda_last <= sda_hi;
        end
    end

    // start/stop seen on the bus, whoever drives it
    always_ff @(posedge sysclk_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
            busy_o <= 1'b0;
        else if (scl_hi && sda_last && !sda_hi)
            busy_o <= 1'b1;
        else if (scl_hi && !sda_last && sda_hi)
            busy_o <= 1'b0;
    end

    // phase tick every prescale+1 clocks
    always_ff @(posedge sysclk_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            cnt  <= '0;
            tick <= 1'b0;
        end
        else if (!enable_i)
        begin
            cnt  <= prescale_i;
            tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt  <= prescale_i;
            tick <= 1'b1;
        end
        else
        begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

    always_ff @(posedge sysclk_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            state     <= BCTL_IDLE;
            scl_oen_o <= 1'b1;
            sda_oen_o <= 1'b1;
            cmd_ack_o <= 1'b0;
            bit_o     <= 1'b1;
            arblost_o <= 1'b0;
        end
        else if (!enable_i)
        begin
            state     <= BCTL_IDLE;
            scl_oen_o <= 1'b1;
            sda_oen_o <= 1'b1;
            cmd_ack_o <= 1'b0;
        end
        else
        begin
            cmd_ack_o <= 1'b0;
            if (tick)
            begin
                case (state)
                    BCTL_IDLE:
                    begin
                        // skip the cycle of the ack, command is being replaced
                        if (!cmd_ack_o)
                        begin
                            case (cmd_i)
                                CMD_START:
                                begin
                                    state     <= START_A;
                                    arblost_o <= 1'b0;
                                end
                                CMD_STOP:  state <= STOP_A;
                                CMD_WRITE: state <= WRITE_A;
                                CMD_READ:  state <= READ_A;
                                default:   state <= BCTL_IDLE;
                            endcase
                        end
                    end
                    START_A:
                    begin
                        sda_oen_o <= 1'b1;              // release sda, scl as it was
                        state     <= START_B;
                    end
                    START_B:
                    begin
                        scl_oen_o <= 1'b1;
                        state     <= START_C;
                    end
                    START_C:
                    begin
                        sda_oen_o <= 1'b0;              // start condition
                        state     <= START_D;
                    end
                    START_D: state <= START_E;          // hold time
                    START_E:
                    begin
                        scl_oen_o <= 1'b0;
                        cmd_ack_o <= 1'b1;
                        state     <= BCTL_IDLE;
                    end
                    STOP_A:
                    begin
                        scl_oen_o <= 1'b0;
                        sda_oen_o <= 1'b0;
                        state     <= STOP_B;
                    end
                    STOP_B:
                    begin
                        scl_oen_o <= 1'b1;
                        state     <= STOP_C;
                    end
                    STOP_C: state <= STOP_D;
                    STOP_D:
                    begin
                        sda_oen_o <= 1'b1;              // stop condition
                        cmd_ack_o <= 1'b1;
                        state     <= BCTL_IDLE;
                    end
                    WRITE_A:
                    begin
                        scl_oen_o <= 1'b0;
                        sda_oen_o <= bit_i;
                        state     <= WRITE_B;
                    end
                    WRITE_B:
                    begin
                        scl_oen_o <= 1'b1;
                        state     <= WRITE_C;
                    end
                    WRITE_C:
                    begin
                        bit_o <= sda_hi;
                        if (sda_oen_o && !sda_hi)
                        begin
                            // someone else holds sda low, back off the bus
                            arblost_o <= 1'b1;
                            scl_oen_o <= 1'b1;
                            sda_oen_o <= 1'b1;
                            state     <= BCTL_IDLE;
                        end
                        else
                            state <= WRITE_D;
                    end
                    WRITE_D:
                    begin
                        scl_oen_o <= 1'b0;
                        cmd_ack_o <= 1'b1;
                        state     <= BCTL_IDLE;
                    end
                    READ_A:
                    begin
                        scl_oen_o <= 1'b0;
                        sda_oen_o <= 1'b1;
                        state     <= READ_B;
                    end
                    READ_B:
                    begin
                        scl_oen_o <= 1'b1;
                        state     <= READ_C;
                    end
                    READ_C:
                    begin
                        bit_o <= sda_hi;                // middle of scl high
                        state <= READ_D;
                    end
                    READ_D:
                    begin
                        scl_oen_o <= 1'b0;
                        cmd_ack_o <= 1'b1;
                        state     <= BCTL_IDLE;
                    end
                    default: state <= BCTL_IDLE;
                endcase
            end
        end
    end

endmodule

//--- hdl/i2c_byte_ctl.sv
`timescale 1ns/1ps

module i2c_byte_ctl
    import i2c_pkg::*;
(
    input  logic     sysclk_i,
    input  logic     reset_n_i,
    input  logic     enable_i,
    input  logic     req_valid_i,
    input  i2c_req_t req_i,
    input  logic     cmd_ack_i,
    input  logic     bit_i,
    input  logic     arblost_i,
    output logic     req_pop_o,
    output bit_cmd_e cmd_o,
    output logic     bit_o,
    output logic     rsp_valid_o,
    output i2c_rsp_t rsp_o
);

    typedef enum logic [2:0]
    {
        IDLE,
        START,
        DATA,
        ACK,
        STOP,
        DONE
    } byte_state_e;

    byte_state_e state;
    i2c_req_t    req_q;
    byte_t       shift_q;
    logic [2:0]  bit_cnt;
    logic        ack_q;
    logic        arb_q;
    logic        arblost_d;
    logic        arb_rise;

    assign req_pop_o   = (state == IDLE) && enable_i && req_valid_i;
    assign arb_rise    = arblost_i && !arblost_d;   // flag stays up until next start
    assign rsp_valid_o = (state == DONE);
    assign rsp_o       = '{data: shift_q, ack_in: ack_q, arblost: arb_q};

    always_comb
    begin
        cmd_o = CMD_IDLE;
        bit_o = 1'b1;
        case (state)
            START: cmd_o = CMD_START;
            DATA:
            begin
                cmd_o = req_q.read ? CMD_READ : CMD_WRITE;
                bit_o = req_q.read ? 1'b1 : shift_q[7];     // msb first
            end
            ACK:
            begin
                // ack goes the other way from the data
                cmd_o = req_q.read ? CMD_WRITE : CMD_READ;
                bit_o = req_q.read ? req_q.ack_n : 1'b1;
            end
            STOP: cmd_o = CMD_STOP;
            default: cmd_o = CMD_IDLE;
        endcase
    end

    always_ff @(posedge sysclk_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
            arblost_d <= 1'b0;
        else
            arblost_d <= arblost_i;
    end

    always_ff @(posedge sysclk_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            state   <= IDLE;
            bit_cnt <= '0;
            ack_q   <= 1'b1;
            arb_q   <= 1'b0;
        end
        else if (state != IDLE && state != DONE && arb_rise)
        begin
            arb_q <= 1'b1;
            state <= DONE;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (req_pop_o)
                    begin
                        bit_cnt <= 3'd7;
                        ack_q   <= 1'b1;
                        arb_q   <= 1'b0;
                        state   <= req_i.start ? START : DATA;
                    end
                end
                START:
                    if (cmd_ack_i)
                        state <= DATA;
                DATA:
                begin
                    if (cmd_ack_i)
                    begin
                        bit_cnt <= bit_cnt - 1'b1;
                        if (bit_cnt == '0)
                            state <= ACK;
                    end
                end
                ACK:
                begin
                    if (cmd_ack_i)
                    begin
                        ack_q <= bit_i;
                        state <= req_q.stop ? STOP : DONE;
                    end
                end
                STOP:
                    if (cmd_ack_i)
                        state <= DONE;
                default: state <= IDLE;                 // done lasts one cycle
            endcase
        end
    end

    // payload, loaded on pop and shifted per data bit
    always_ff @(posedge sysclk_i)
    begin
        if (req_pop_o)
        begin
            req_q   <= req_i;
            shift_q <= req_i.data;
        end
        else if (state == DATA && cmd_ack_i)
            shift_q <= {shift_q[6:0], bit_i};       // bus value, echo on writes
    end

endmodule

//--- hdl/i2c_cmd_fifo.sv
`timescale 1ns/1ps

module i2c_cmd_fifo
    import i2c_pkg::*;
#(
    parameter int DEPTH = 4
)
(
    input  logic     sysclk_i,
    input  logic     reset_n_i,
    input  logic     push_i,
    input  i2c_req_t push_data_i,
    input  logic     pop_i,
    output logic     valid_o,
    output i2c_req_t pop_data_o,
    output logic     credit_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    i2c_req_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;

    assign valid_o    = (count != '0);
    assign do_pop     = pop_i && valid_o;
    assign pop_data_o = mem[rd_ptr];

    always_ff @(posedge sysclk_i)
    begin
        if (push_i)
            mem[wr_ptr] <= push_data_i;
    end

    always_ff @(posedge sysclk_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end
        else
        begin
            credit_o <= do_pop;                     // one credit back per entry out
            if (push_i)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push_i && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !push_i)
                count <= count - 1'b1;
        end
    end

endmodule

//--- hdl/i2c_master_top.sv
`timescale 1ns/1ps

module i2c_master_top
    import i2c_pkg::*;
#(
    parameter int DEPTH = 4
)
(
    input  logic      sysclk_i,
    input  logic      reset_n_i,
    input  logic      enable_i,
    input  prescale_t prescale_i,
    input  logic      req_valid_i,
    input  i2c_req_t  req_i,
    input  logic      scl_i,
    input  logic      sda_i,
    output logic      credit_o,
    output logic      rsp_valid_o,
    output i2c_rsp_t  rsp_o,
    output logic      busy_o,
    output logic      scl_oen_o,
    output logic      sda_oen_o
);

    logic     fifo_valid;
    i2c_req_t fifo_req;
    logic     fifo_pop;
    bit_cmd_e bit_cmd;
    logic     bit_tx;
    logic     cmd_ack;
    logic     bit_rx;
    logic     arblost;

    i2c_cmd_fifo #(
        .DEPTH (DEPTH)
    ) i_i2c_cmd_fifo (
        .sysclk_i    (sysclk_i),
        .reset_n_i   (reset_n_i),
        .push_i      (req_valid_i),
        .push_data_i (req_i),
        .pop_i       (fifo_pop),
        .valid_o     (fifo_valid),
        .pop_data_o  (fifo_req),
        .credit_o    (credit_o)
    );

    i2c_byte_ctl i_i2c_byte_ctl (
        .sysclk_i    (sysclk_i),
        .reset_n_i   (reset_n_i),
        .enable_i    (enable_i),
        .req_valid_i (fifo_valid),
        .req_i       (fifo_req),
        .cmd_ack_i   (cmd_ack),
        .bit_i       (bit_rx),
        .arblost_i   (arblost),
        .req_pop_o   (fifo_pop),
        .cmd_o       (bit_cmd),
        .bit_o       (bit_tx),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

    i2c_bit_ctl i_i2c_bit_ctl (
        .sysclk_i    (sysclk_i),
        .reset_n_i   (reset_n_i),
        .enable_i    (enable_i),
        .prescale_i  (prescale_i),
        .cmd_i       (bit_cmd),
        .bit_i       (bit_tx),
        .scl_i       (scl_i),
        .sda_i       (sda_i),
        .cmd_ack_o   (cmd_ack),
        .bit_o       (bit_rx),
        .arblost_o   (arblost),
        .busy_o      (busy_o),
        .scl_oen_o   (scl_oen_o),
        .sda_oen_o   (sda_oen_o)
    );

endmodule

//--- hdl/i2c_pkg.sv
package i2c_pkg;

    // phase length in system clocks, minus one
    typedef logic [15:0] prescale_t;

    typedef logic [7:0]  byte_t;

    // bit commands from the byte engine
    typedef enum logic [2:0]
    {
        CMD_IDLE  = 3'd0,
        CMD_START = 3'd1,
        CMD_STOP  = 3'd2,
        CMD_WRITE = 3'd3,   // also used to send the master ack
        CMD_READ  = 3'd4    // also used to sample the slave ack
    } bit_cmd_e;

    typedef enum logic [4:0]
    {
        BCTL_IDLE,
        START_A, START_B, START_C, START_D, START_E,
        STOP_A,  STOP_B,  STOP_C,  STOP_D,
        WRITE_A, WRITE_B, WRITE_C, WRITE_D,
        READ_A,  READ_B,  READ_C,  READ_D
    } bit_state_e;

    typedef struct packed
    {
        logic  start;
        logic  stop;
        logic  read;
        logic  ack_n;       // ack value sent after a read byte
        byte_t data;
    } i2c_req_t;

    typedef struct packed
    {
        byte_t data;        // byte seen on the bus
        logic  ack_in;
        logic  arblost;
    } i2c_rsp_t;

endpackage

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -f src.f --top-module tb_i2c_master -o sim_tb \
    > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    && cat sim.log \
    && grep -q "^RESULT: PASS$" sim.log \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- src.f
hdl/i2c_pkg.sv
hdl/i2c_cmd_fifo.sv
hdl/i2c_bit_ctl.sv
hdl/i2c_byte_ctl.sv
hdl/i2c_master_top.sv
verification/tb_clock_gen.sv
verification/i2c_slave_model.sv
verification/tb_i2c_master.sv

//--- verification/i2c_slave_model.sv
`timescale 1ns/1ps

module i2c_slave_model
#(
    parameter logic [6:0] ADDR = 7'h2A
)
(
    input  logic sysclk_i,
    input  logic reset_n_i,
    input  logic scl_oen_i,
    input  logic sda_oen_i,
    input  logic sda_force_low_i,
    output logic scl_o,
    output logic sda_o
);

    typedef enum logic [1:0]
    {
        S_IDLE,
        S_ADDR,
        S_RX,
        S_TX
    } slave_state_e;

    slave_state_e state;
    logic [7:0]   data_reg;
    logic [7:0]   shift;
    logic [3:0]   cnt;                          // scl rises seen in this byte
    logic         sda_drv;
    logic         rd_q;
    logic         scl_q;
    logic         sda_q;

    // wired AND of every driver on the bus
    assign scl_o = scl_oen_i;
    assign sda_o = sda_oen_i & sda_drv & ~sda_force_low_i;

    always_ff @(posedge sysclk_i or negedge reset_n_i)
    begin
        if (!reset_n_i)
        begin
            state    <= S_IDLE;
            data_reg <= 8'h00;
            shift    <= 8'h00;
            cnt      <= 4'd0;
            sda_drv  <= 1'b1;
            rd_q     <= 1'b0;
            scl_q    <= 1'b1;
            sda_q    <= 1'b1;
        end
        else
        begin
            scl_q <= scl_o;
            sda_q <= sda_o;
            if (scl_q && scl_o && sda_q && !sda_o)
            begin
                state   <= S_ADDR;              // start
                cnt     <= 4'd0;
                sda_drv <= 1'b1;
            end
            else if (scl_q && scl_o && !sda_q && sda_o)
            begin
                state   <= S_IDLE;              // stop
                sda_drv <= 1'b1;
            end
            else if (state != S_IDLE)
            begin
                if (!scl_q && scl_o)
                begin
                    shift <= {shift[6:0], sda_o};
                    cnt   <= cnt + 4'd1;
                end
                else if (scl_q && !scl_o)
                begin
                    if (cnt == 4'd8)
                    begin
                        case (state)
                            S_ADDR:
                            begin
                                rd_q <= shift[0];
                                if (shift[7:1] == ADDR)
                                    sda_drv <= 1'b0;
                                else
                                    state <= S_IDLE;    // not ours
                            end
                            S_RX:
                            begin
                                data_reg <= shift;
                                sda_drv  <= 1'b0;
                            end
                            default: sda_drv <= 1'b1;   // master acks our byte
                        endcase
                    end
                    else if (cnt == 4'd9)
                    begin
                        cnt     <= 4'd0;
                        sda_drv <= 1'b1;
                        if (state == S_ADDR)
                        begin
                            state <= rd_q ? S_TX : S_RX;
                            if (rd_q)
                                sda_drv <= data_reg[7];
                        end
                    end
                    else if (state == S_TX && cnt != 4'd0)
                        sda_drv <= data_reg[3'd7 - cnt[2:0]];
                end
            end
        end
    end

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
#(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 16
)
(
    output logic sysclk_o,
    output logic reset_n_o
);

    initial
    begin
        sysclk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) sysclk_o = ~sysclk_o;
    end

    initial
    begin
        reset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge sysclk_o);
        @(negedge sysclk_o);
        reset_n_o = 1'b1;                       // release away from the active edge
    end

endmodule

//--- verification/tb_i2c_master.sv
`timescale 1ns/1ps

module tb_i2c_master
    import i2c_pkg::*;
;

    localparam int     DEPTH      = 4;
    localparam int     PRESCALE   = 3;
    localparam int     N_REQ      = 14;
    localparam longint TIMEOUT_NS = longint'(N_REQ * 12 * 4 * (PRESCALE + 1) * 8 * 2 + 16 * 8);

    logic      sysclk;
    logic      reset_n;
    logic      enable;
    prescale_t prescale;
    logic      req_valid;
    i2c_req_t  req;
    logic      scl;
    logic      sda;
    logic      credit;
    logic      rsp_valid;
    i2c_rsp_t  rsp;
    logic      busy;
    logic      scl_oen;
    logic      sda_oen;
    logic      force_low;

    i2c_rsp_t  exp_q [$];
    logic      full_q [$];
    string     name_q [$];
    i2c_rsp_t  exp_rsp;
    logic      exp_full;
    string     exp_name;
    int        credits = DEPTH;
    int        credit_pulses = 0;
    int        rsp_count = 0;
    int        errors = 0;
    int        tests_run = 0;
    int        tests_failed = 0;
    int        test_err0;
    int        seed = 23203;

    tb_clock_gen #(.PERIOD_NS(8.0), .RESET_CYCLES(16)) i_tb_clock_gen (
        .sysclk_o  (sysclk),
        .reset_n_o (reset_n)
    );

    i2c_master_top #(.DEPTH(DEPTH)) i_i2c_master_top (
        .sysclk_i    (sysclk),
        .reset_n_i   (reset_n),
        .enable_i    (enable),
        .prescale_i  (prescale),
        .req_valid_i (req_valid),
        .req_i       (req),
        .scl_i       (scl),
        .sda_i       (sda),
        .credit_o    (credit),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp),
        .busy_o      (busy),
        .scl_oen_o   (scl_oen),
        .sda_oen_o   (sda_oen)
    );

    i2c_slave_model #(.ADDR(7'h2A)) i_i2c_slave_model (
        .sysclk_i        (sysclk),
        .reset_n_i       (reset_n),
        .scl_oen_i       (scl_oen),
        .sda_oen_i       (sda_oen),
        .sda_force_low_i (force_low),
        .scl_o           (scl),
        .sda_o           (sda)
    );

    initial
    begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, a transfer never finished", TIMEOUT_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    // credit and response monitor
    always @(posedge sysclk)
    begin
        if (credit)
        begin
            credits++;
            credit_pulses++;
            assert (credits <= DEPTH)
            else
            begin
                $display("more credits returned than requests pushed");
                errors++;
            end
        end
        if (rsp_valid)
        begin
            rsp_count++;
            if (exp_q.size() == 0)
            begin
                $display("response arrived with no request outstanding");
                errors++;
            end
            else
            begin
                exp_rsp  = exp_q.pop_front();
                exp_full = full_q.pop_front();
                exp_name = name_q.pop_front();
                if (exp_full)
                    assert (rsp == exp_rsp)
                    else
                    begin
                        $display("FAIL %s: expected %h, actual %h", exp_name, exp_rsp, rsp);
                        errors++;
                    end
                else
                    assert (rsp.arblost == exp_rsp.arblost)
                    else
                    begin
                        $display("FAIL %s: expected arblost %b, actual %b", exp_name,
                                 exp_rsp.arblost, rsp.arblost);
                        errors++;
                    end
            end
        end
    end

    function automatic i2c_req_t make_req(input logic start, input logic stop,
                                          input logic read, input byte_t data);
        i2c_req_t r;
        r.start = start;
        r.stop  = stop;
        r.read  = read;
        r.ack_n = 1'b1;                         // nack ends every read here
        r.data  = data;
        return r;
    endfunction

    function automatic i2c_rsp_t make_rsp(input byte_t data, input logic ack_in,
                                          input logic arblost);
        i2c_rsp_t r;
        r.data    = data;
        r.ack_in  = ack_in;
        r.arblost = arblost;
        return r;
    endfunction

    // starts and ends on a falling edge
    task automatic push_req(input i2c_req_t r, input i2c_rsp_t e, input logic full,
                            input string name);
        while (credits == 0)
            @(negedge sysclk);
        req_valid = 1'b1;
        req       = r;
        credits--;
        exp_q.push_back(e);
        full_q.push_back(full);
        name_q.push_back(name);
        @(negedge sysclk);
        req_valid = 1'b0;
    endtask

    task automatic wait_results();
        while (exp_q.size() != 0)
            @(negedge sysclk);
    endtask

    task automatic wait_bus_free();
        int n;
        n = 0;
        while (busy && n < 8)
        begin
            @(negedge sysclk);
            n++;
        end
        assert (!busy)
        else
        begin
            $display("busy still set after the stop condition");
            errors++;
        end
    endtask

    task automatic begin_test();
        test_err0 = errors;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        if (errors != test_err0)
        begin
            tests_failed++;
            $display("test %s: failed", name);
        end
        else
            $display("test %s: ok", name);
    endtask

    initial
    begin
        byte_t wr_byte;
        byte_t d;
        int    pulses0;
        int    target;
        enable    = 1'b1;
        prescale  = prescale_t'(PRESCALE);
        req_valid = 1'b0;
        req       = '0;
        force_low = 1'b0;
        wait (reset_n === 1'b1);
        @(negedge sysclk);

        begin_test();
        assert (scl_oen && sda_oen && !busy && !credit && !rsp_valid)
        else
        begin
            $display("outputs not in their reset state");
            errors++;
        end
        end_test("reset_state");

        begin_test();
        push_req(make_req(1, 0, 0, 8'h54), make_rsp(8'h54, 0, 0), 1, "addr_ack");
        wait_results();
        assert (busy)
        else
        begin
            $display("busy not set after the start condition");
            errors++;
        end
        push_req(make_req(1, 1, 0, 8'h66), make_rsp(8'h66, 1, 0), 1, "addr_nack");
        wait_results();
        wait_bus_free();
        end_test("address_ack");

        begin_test();
        wr_byte = 8'($random(seed));
        push_req(make_req(1, 0, 0, 8'h54), make_rsp(8'h54, 0, 0), 1, "wr_addr");
        push_req(make_req(0, 1, 0, wr_byte), make_rsp(wr_byte, 0, 0), 1, "wr_data");
        push_req(make_req(1, 0, 0, 8'h55), make_rsp(8'h55, 0, 0), 1, "rd_addr");
        push_req(make_req(0, 1, 1, 8'hFF), make_rsp(wr_byte, 1, 0), 1, "rd_data");
        wait_results();
        wait_bus_free();
        end_test("write_read_back");

        begin_test();
        pulses0 = credit_pulses;
        push_req(make_req(1, 0, 0, 8'h54), make_rsp(8'h54, 0, 0), 1, "burst_addr");
        for (int i = 0; i < 5; i++)
        begin
            d = 8'($random(seed));
            push_req(make_req(0, i == 4, 0, d), make_rsp(d, 0, 0), 1, "burst_data");
        end
        wait_results();
        wait_bus_free();
        assert (credit_pulses - pulses0 == 6 && credits == DEPTH)
        else
        begin
            $display("FAIL credits: expected 6 pulses, actual %0d", credit_pulses - pulses0);
            errors++;
        end
        end_test("credits");

        begin_test();
        target = rsp_count + 1;
        push_req(make_req(1, 0, 0, 8'hFF), make_rsp(8'hFF, 1, 1), 0, "arb_lost");
        push_req(make_req(1, 1, 0, 8'h54), make_rsp(8'h54, 0, 0), 1, "after_arb");
        while (!busy)
            @(negedge sysclk);
        force_low = 1'b1;                       // another master holds sda
        while (rsp_count < target)
            @(negedge sysclk);
        assert (scl_oen && sda_oen)
        else
        begin
            $display("master still drives the bus after losing arbitration");
            errors++;
        end
        force_low = 1'b0;
        wait_results();
        wait_bus_free();
        end_test("arbitration");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule
